// ==== hydro_pkg.sv ====
// Hydrogen bus package with the Wishbone structs, memory map and size constants
package hydro_pkg;

    ////////////////////
    // Wishbone classic
    ////////////////////

    // Master to slave request, one transfer per ack
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic        we;
        logic [3:0]  sel;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    // Slave to master response
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    // Decoded bus target
    typedef enum logic [1:0] {
        SLV_NONE = 2'd0,
        SLV_RAM  = 2'd1,
        SLV_GPIO = 2'd2
    } slave_sel_t;

    ////////////////////
    // Memory map
    ////////////////////

    // Word RAM window
    localparam logic [31:0] RAM_BASE = 32'h0000_0000;
    localparam logic [31:0] RAM_SIZE = 32'd4096;

    // Word address bits, RAM_SIZE/4 words
    localparam int unsigned RAM_AW    = 10;
    localparam int unsigned RAM_WORDS = RAM_SIZE / 4;

    // GPIO window
    localparam logic [31:0] GPIO_BASE = 32'h1000_0000;
    localparam logic [31:0] GPIO_SIZE = 32'd16;

    // Pin count
    localparam int unsigned NGPIO = 8;

    // GPIO register offsets inside the window
    localparam logic [3:0] GPIO_OUT_OFS = 4'h0;
    localparam logic [3:0] GPIO_IN_OFS  = 4'h4;
    localparam logic [3:0] GPIO_TGL_OFS = 4'h8;

endpackage

// ==== hydro_arbiter.sv ====
// Two-master bus arbiter with registered grant and alternating priority on ties
`timescale 1ns/10ps

module hydro_arbiter import hydro_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,

    // Instruction port
    input  wb_req_t m0_req_i,
    output wb_rsp_t m0_rsp_o,

    // Data port
    input  wb_req_t m1_req_i,
    output wb_rsp_t m1_rsp_o,

    // Shared bus
    output wb_req_t bus_req_o,
    input  wb_rsp_t bus_rsp_i
);

    // Grant state, index 0 is the instruction port
    logic gnt_vld_q;
    logic gnt_idx_q;
    logic last_q;

    logic gnt_vld_d;
    logic gnt_idx_d;
    logic hold;

    // Instruction port never writes
    wb_req_t m0_fwd;

    always_comb begin
        m0_fwd     = m0_req_i;
        m0_fwd.we  = 1'b0;
        m0_fwd.dat = '0;
    end

    // Owner keeps the bus while its cycle lasts
    assign hold = gnt_vld_q && (gnt_idx_q ? m1_req_i.cyc : m0_req_i.cyc);

    ////////////////////
    // Next grant
    always_comb begin
        gnt_vld_d = 1'b0;
        gnt_idx_d = gnt_idx_q;
        if (hold) begin
            gnt_vld_d = 1'b1;
        end else if (m0_req_i.cyc && m1_req_i.cyc) begin
            // Tie goes to whoever was not served last
            gnt_vld_d = 1'b1;
            gnt_idx_d = ~last_q;
        end else if (m0_req_i.cyc) begin
            gnt_vld_d = 1'b1;
            gnt_idx_d = 1'b0;
        end else if (m1_req_i.cyc) begin
            gnt_vld_d = 1'b1;
            gnt_idx_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gnt_vld_q <= 1'b0;
            gnt_idx_q <= 1'b0;
            last_q    <= 1'b1;
        end else begin
            gnt_vld_q <= gnt_vld_d;
            gnt_idx_q <= gnt_idx_d;
            if (gnt_vld_d && !hold) begin
                last_q <= gnt_idx_d;
            end
        end
    end

    ////////////////////
    // Request and response routing
    always_comb begin
        bus_req_o = '0;
        m0_rsp_o  = '0;
        m1_rsp_o  = '0;
        if (gnt_vld_q) begin
            if (gnt_idx_q) begin
                bus_req_o = m1_req_i;
                m1_rsp_o  = bus_rsp_i;
            end else begin
                bus_req_o = m0_fwd;
                m0_rsp_o  = bus_rsp_i;
            end
        end
    end

endmodule

// ==== hydro_decoder.sv ====
// Address decoder steering strobes to RAM or GPIO and answering unmapped accesses
`timescale 1ns/10ps

module hydro_decoder import hydro_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,

    // From the arbiter
    input  wb_req_t bus_req_i,

    // Slave strobes
    output logic    ram_stb_o,
    output logic    gpio_stb_o,

    // Slave responses
    input  wb_rsp_t ram_rsp_i,
    input  wb_rsp_t gpio_rsp_i,

    // Back to the arbiter
    output wb_rsp_t bus_rsp_o,
    output logic    bus_err_o
);

    slave_sel_t  slv;
    logic [31:0] ram_ofs;
    logic [31:0] gpio_ofs;
    logic        err_ack_q;

    // Offsets wrap below the base, so one compare per window
    assign ram_ofs  = bus_req_i.adr - RAM_BASE;
    assign gpio_ofs = bus_req_i.adr - GPIO_BASE;

    ////////////////////
    // Slave select
    always_comb begin
        slv = SLV_NONE;
        if (bus_req_i.cyc) begin
            if (ram_ofs < RAM_SIZE) begin
                slv = SLV_RAM;
            end else if (gpio_ofs < GPIO_SIZE) begin
                slv = SLV_GPIO;
            end
        end
    end

    assign ram_stb_o  = (slv == SLV_RAM) && bus_req_i.stb;
    assign gpio_stb_o = (slv == SLV_GPIO) && bus_req_i.stb;

    // Unmapped access, acked once with an error pulse
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= bus_req_i.cyc && bus_req_i.stb && (slv == SLV_NONE) && !err_ack_q;
        end
    end

    assign bus_err_o = err_ack_q;

    ////////////////////
    // Response mux
    always_comb begin
        case (slv)
            SLV_RAM:  bus_rsp_o = ram_rsp_i;
            SLV_GPIO: bus_rsp_o = gpio_rsp_i;
            default: begin
                bus_rsp_o.dat = '0;
                bus_rsp_o.ack = err_ack_q;
            end
        endcase
    end

endmodule

// ==== hydro_ram.sv ====
// Word RAM slave with byte-lane writes and a registered one-cycle ack
`timescale 1ns/10ps

module hydro_ram import hydro_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  wb_req_t req_i,
    input  logic    stb_i,
    output wb_rsp_t rsp_o
);

    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] widx;
    logic [31:0]       rd_dat_q;
    logic              ack_q;
    logic              access;

    // Byte address to word index
    assign widx   = req_i.adr[RAM_AW+1:2];
    assign access = stb_i && !ack_q;

    ////////////////////
    // Storage and read data
    always_ff @(posedge clk_i) begin
        if (access) begin
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.sel[b]) begin
                        mem[widx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
                rd_dat_q <= '0;
            end else begin
                rd_dat_q <= mem[widx];
            end
        end
    end

    // One ack per strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign rsp_o.dat = rd_dat_q;
    assign rsp_o.ack = ack_q;

endmodule

// ==== hydro_gpio.sv ====
// GPIO slave with output, synchronized input and toggle registers
`timescale 1ns/10ps

module hydro_gpio import hydro_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_i,
    input  wb_req_t          req_i,
    input  logic             stb_i,
    output wb_rsp_t          rsp_o,
    input  logic [NGPIO-1:0] gpio_in_i,
    output logic [NGPIO-1:0] gpio_out_o
);

    logic [NGPIO-1:0] sync1_q;
    logic [NGPIO-1:0] sync2_q;
    logic [NGPIO-1:0] out_q;
    logic [31:0]      rd_dat_q;
    logic             ack_q;
    logic             access;
    logic             wr_lane;
    logic [3:0]       ofs;
    logic [NGPIO-1:0] wdat;

    assign access  = stb_i && !ack_q;
    assign wr_lane = req_i.we && req_i.sel[0];
    assign ofs     = {req_i.adr[3:2], 2'b00};
    assign wdat    = req_i.dat[NGPIO-1:0];

    // Two-flop input synchronizer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
        end
    end

    ////////////////////
    // Register writes and ack
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && wr_lane) begin
                if (ofs == GPIO_OUT_OFS) begin
                    out_q <= wdat;
                end else if (ofs == GPIO_TGL_OFS) begin
                    out_q <= out_q ^ wdat;
                end
            end
        end
    end

    // Read data, toggle and spare offsets read zero
    always_ff @(posedge clk_i) begin
        if (access) begin
            rd_dat_q <= '0;
            if (!req_i.we) begin
                if (ofs == GPIO_OUT_OFS) begin
                    rd_dat_q[NGPIO-1:0] <= out_q;
                end else if (ofs == GPIO_IN_OFS) begin
                    rd_dat_q[NGPIO-1:0] <= sync2_q;
                end
            end
        end
    end

    assign rsp_o.dat  = rd_dat_q;
    assign rsp_o.ack  = ack_q;
    assign gpio_out_o = out_q;

endmodule

// ==== hydro_soc.sv ====
// Hydrogen bus top level with arbiter, decoder, word RAM and GPIO
`timescale 1ns/10ps

module hydro_soc import hydro_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_i,

    // Instruction port, read only
    input  wb_req_t          m0_req_i,
    output wb_rsp_t          m0_rsp_o,

    // Data port
    input  wb_req_t          m1_req_i,
    output wb_rsp_t          m1_rsp_o,

    // GPIO pins
    input  logic [NGPIO-1:0] gpio_in_i,
    output logic [NGPIO-1:0] gpio_out_o,

    // Unmapped access flag
    output logic             bus_err_o
);

    ////////////////////
    // Shared bus
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;

    // Slave side
    logic    ram_stb;
    logic    gpio_stb;
    wb_rsp_t ram_rsp;
    wb_rsp_t gpio_rsp;

    hydro_arbiter arb_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .m0_req_i  (m0_req_i),
        .m0_rsp_o  (m0_rsp_o),
        .m1_req_i  (m1_req_i),
        .m1_rsp_o  (m1_rsp_o),
        .bus_req_o (bus_req),
        .bus_rsp_i (bus_rsp)
    );

    hydro_decoder dec_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .bus_req_i  (bus_req),
        .ram_stb_o  (ram_stb),
        .gpio_stb_o (gpio_stb),
        .ram_rsp_i  (ram_rsp),
        .gpio_rsp_i (gpio_rsp),
        .bus_rsp_o  (bus_rsp),
        .bus_err_o  (bus_err_o)
    );

    ////////////////////
    // Slaves
    hydro_ram ram_i (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (bus_req),
        .stb_i (ram_stb),
        .rsp_o (ram_rsp)
    );

    hydro_gpio gpio_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (bus_req),
        .stb_i      (gpio_stb),
        .rsp_o      (gpio_rsp),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o)
    );

endmodule

// ==== tb_hydro_soc.sv ====
// Testbench for the bus subsystem, two random masters checked against a reference model
`timescale 1ns/10ps

module tb_hydro_soc import hydro_pkg::*; ();

    localparam int RST_CYCLES     = 10;
    localparam int NUM_XFER       = 150;
    localparam int PRELOAD_WORDS  = 32;
    localparam int TIMEOUT_CYCLES = 20 * (2 * NUM_XFER + PRELOAD_WORDS) + RST_CYCLES;

    logic             clk_i = 1'b0;
    logic             rst_i;
    wb_req_t          m0_req;
    wb_req_t          m1_req;
    wb_rsp_t          m0_rsp;
    wb_rsp_t          m1_rsp;
    logic [NGPIO-1:0] gpio_in;
    logic [NGPIO-1:0] gpio_out;
    logic             bus_err;

    // Reference model state
    logic [31:0]      model_mem [RAM_WORDS];
    logic [NGPIO-1:0] model_out;
    logic [NGPIO-1:0] model_in;

    logic [31:0]      lfsr [2];
    logic [1:0]       unm_pend;
    int               ack_cnt [2];
    int               cycles = 0;
    int               value_errs;
    int               proto_errs;

    // Request order for the arbitration check
    int               start_cyc [2];
    logic [1:0]       pend;
    logic             last_srv;

    hydro_soc dut_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .m0_req_i   (m0_req),
        .m0_rsp_o   (m0_rsp),
        .m1_req_i   (m1_req),
        .m1_rsp_o   (m1_rsp),
        .gpio_in_i  (gpio_in),
        .gpio_out_o (gpio_out),
        .bus_err_o  (bus_err)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the masters did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////
    // Random numbers and checks

    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            st  = st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
            val = {val[30:0], st[0]};
        end
        return val;
    endfunction

    task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            value_errs = value_errs + 1;
        end
    endtask

    task automatic check_gpio(input string name, input logic [NGPIO-1:0] exp,
                              input logic [NGPIO-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            value_errs = value_errs + 1;
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            value_errs = value_errs + 1;
        end
    endtask

    // Both windows are aligned to their power-of-two sizes
    function automatic slave_sel_t region_of(input logic [31:0] adr);
        if ((adr & ~(RAM_SIZE - 32'd1)) == RAM_BASE) begin
            return SLV_RAM;
        end else if ((adr & ~(GPIO_SIZE - 32'd1)) == GPIO_BASE) begin
            return SLV_GPIO;
        end
        return SLV_NONE;
    endfunction

    // Error flag must follow exactly the acks of unmapped accesses
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if ((m0_rsp.ack && !m0_req.stb) || (m1_rsp.ack && !m1_req.stb)) begin
                $display("Ack seen on a port with no request pending at cycle %0d", cycles);
                proto_errs = proto_errs + 1;
            end
            if (m0_rsp.ack && m1_rsp.ack) begin
                $display("Both ports were acked in the same cycle at cycle %0d", cycles);
                proto_errs = proto_errs + 1;
            end
            check_err("bus error flag", (m0_rsp.ack && unm_pend[0]) ||
                      (m1_rsp.ack && unm_pend[1]), bus_err);
        end
    end

    ////////////////////
    // Masters

    task automatic drive_req(input logic idx, input wb_req_t r);
        if (idx) begin
            m1_req <= r;
        end else begin
            m0_req <= r;
        end
    endtask

    // One classic cycle that drops in the cycle after the ack
    task automatic bus_xfer(input logic idx, input wb_req_t req, output wb_rsp_t rsp);
        wb_rsp_t cur;
        @(posedge clk_i);
        unm_pend[idx]  = (region_of(req.adr) == SLV_NONE);
        start_cyc[idx] = cycles;
        pend[idx]      = 1'b1;
        drive_req(idx, req);
        do begin
            @(negedge clk_i);
            cur = idx ? m1_rsp : m0_rsp;
        end while (!cur.ack);
        // Older request goes first, a tie goes to the port not served last
        if (pend[~idx] && ((start_cyc[~idx] < start_cyc[idx]) ||
            (start_cyc[~idx] == start_cyc[idx] && last_srv == idx))) begin
            $display("Port %0d was served out of request order at cycle %0d", idx, cycles);
            proto_errs = proto_errs + 1;
        end
        pend[idx] = 1'b0;
        last_srv  = idx;
        rsp = cur;
        @(posedge clk_i);
        drive_req(idx, '0);
    endtask

    function automatic wb_req_t pick_req(inout logic [31:0] st, input logic writer);
        wb_req_t     r;
        logic [31:0] tgt;
        logic [31:0] ofs;
        r     = '0;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.sel = 4'(take_bits(st, 4));
        r.dat = take_bits(st, 32);
        r.we  = writer && (take_bits(st, 1) != 0);
        tgt   = take_bits(st, 2);
        if (tgt < 2) begin
            // Spread 32 words over the whole RAM
            r.adr = RAM_BASE + take_bits(st, 5) * 32'd132;
        end else if (tgt == 2) begin
            ofs = take_bits(st, 2) << 2;
            if (!writer && ofs == {28'd0, GPIO_IN_OFS}) begin
                ofs = {28'd0, GPIO_OUT_OFS};
            end
            r.adr = GPIO_BASE + ofs;
        end else begin
            // Just past the end of either window
            r.adr = (take_bits(st, 1) != 0) ? RAM_BASE + RAM_SIZE : GPIO_BASE + GPIO_SIZE;
            r.adr = r.adr + (take_bits(st, 8) << 2);
        end
        return r;
    endfunction

    task automatic complete(input wb_req_t req, input wb_rsp_t rsp);
        wb_rsp_t           exp;
        logic [31:0]       mask;
        logic [RAM_AW-1:0] widx;
        logic [3:0]        ofs;
        exp     = '0;
        exp.ack = 1'b1;
        widx    = req.adr[RAM_AW+1:2];
        ofs     = req.adr[3:0];
        mask    = {{8{req.sel[3]}}, {8{req.sel[2]}}, {8{req.sel[1]}}, {8{req.sel[0]}}};
        case (region_of(req.adr))
            SLV_RAM: begin
                if (req.we) begin
                    model_mem[widx] = (model_mem[widx] & ~mask) | (req.dat & mask);
                end else begin
                    exp.dat = model_mem[widx];
                end
                check_rsp(req.we ? "ram write" : "ram read", exp, rsp);
            end
            SLV_GPIO: begin
                if (req.we) begin
                    if (req.sel[0] && ofs == GPIO_OUT_OFS) begin
                        model_out = req.dat[NGPIO-1:0];
                    end else if (req.sel[0] && ofs == GPIO_TGL_OFS) begin
                        model_out = model_out ^ req.dat[NGPIO-1:0];
                    end
                    check_rsp("gpio write", exp, rsp);
                    check_gpio("gpio pins after write", model_out, gpio_out);
                end else begin
                    if (ofs == GPIO_OUT_OFS) begin
                        exp.dat[NGPIO-1:0] = model_out;
                    end else if (ofs == GPIO_IN_OFS) begin
                        exp.dat[NGPIO-1:0] = model_in;
                    end
                    check_rsp("gpio read", exp, rsp);
                end
            end
            default: check_rsp("unmapped access", exp, rsp);
        endcase
    endtask

    task automatic run_master(input logic idx);
        wb_req_t     req;
        wb_rsp_t     rsp;
        logic [31:0] gap;
        logic [31:0] pins;
        int          seen;
        for (int n = 0; n < NUM_XFER; n++) begin
            gap = take_bits(lfsr[idx], 2);
            repeat (gap) @(posedge clk_i);
            req = pick_req(lfsr[idx], idx);
            // New pin value settles through the synchronizer first
            if (!req.we && req.adr == GPIO_BASE + {28'd0, GPIO_IN_OFS}) begin
                pins = take_bits(lfsr[idx], NGPIO);
                @(posedge clk_i);
                gpio_in  <= pins[NGPIO-1:0];
                model_in  = pins[NGPIO-1:0];
                repeat (3) @(posedge clk_i);
            end
            seen = ack_cnt[~idx];
            bus_xfer(idx, req, rsp);
            if (ack_cnt[~idx] - seen > 1) begin
                $display("Port %0d waited for more than one other transfer", idx);
                proto_errs = proto_errs + 1;
            end
            ack_cnt[idx] = ack_cnt[idx] + 1;
            complete(req, rsp);
        end
    endtask

    ////////////////////
    // Main sequence
    initial begin
        wb_req_t req;
        wb_rsp_t rsp;
        rst_i      <= 1'b1;
        m0_req     <= '0;
        m1_req     <= '0;
        gpio_in    <= '0;
        model_out   = '0;
        model_in    = '0;
        unm_pend    = '0;
        pend        = '0;
        last_srv    = 1'b1;
        start_cyc[0] = 0;
        start_cyc[1] = 0;
        ack_cnt[0]  = 0;
        ack_cnt[1]  = 0;
        value_errs  = 0;
        proto_errs  = 0;
        lfsr[0]     = 32'h537f;
        lfsr[1]     = 32'h537f;
        // Data port runs further along the same sequence
        void'(take_bits(lfsr[1], 1000));
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        repeat (3) begin
            @(negedge clk_i);
            check_rsp("idle instruction port", '0, m0_rsp);
            check_rsp("idle data port", '0, m1_rsp);
            check_err("idle error flag", 1'b0, bus_err);
            check_gpio("gpio pins after reset", '0, gpio_out);
        end

        // Full words first so every read address holds known data
        for (int w = 0; w < PRELOAD_WORDS; w++) begin
            req     = '0;
            req.cyc = 1'b1;
            req.stb = 1'b1;
            req.we  = 1'b1;
            req.sel = 4'hf;
            req.adr = RAM_BASE + 32'(w) * 32'd132;
            req.dat = take_bits(lfsr[1], 32);
            bus_xfer(1'b1, req, rsp);
            complete(req, rsp);
        end

        fork
            run_master(1'b0);
            run_master(1'b1);
        join

        $display("Errors: %0d value mismatches, %0d protocol failures", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hydro_pkg.sv
hydro_arbiter.sv
hydro_decoder.sv
hydro_ram.sv
hydro_gpio.sv
hydro_soc.sv
tb_hydro_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the bus subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_hydro_soc -o tb_hydro_soc
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_hydro_soc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
exit 1
